//--- sram_bridge.f
logic/sram_bridge_pkg.sv
logic/sram_port_if.sv
logic/tl_req_checker.sv
logic/sync_fifo.sv
logic/tl_sram_adapter.sv
logic/sram_array.sv
logic/sram_bridge_top.sv
verification/sram_bridge_tb.sv

//--- verification/sram_bridge_tb.sv
// Self-checking testbench for the TileLink-UL to SRAM bridge with a shadow
// memory, an in-order response scoreboard and concurrent assertions
`timescale 1ns/100ps

module sram_bridge_tb import sram_bridge_pkg::*; ();

  localparam int sram_aw     = 10;
  localparam int outstanding = 2;
  localparam int max_cycles  = 4000;

  // One expected D response is captured when its request is accepted
  typedef struct packed {
    logic [2:0]  opcode;
    logic [1:0]  size;
    logic [7:0]  source;
    logic [31:0] data;
    logic        error;
  } resp_t;

  logic        clk_i;
  logic        rst_i;
  logic        a_valid_i;
  logic        a_ready_o;
  logic [2:0]  a_opcode_i;
  logic [1:0]  a_size_i;
  logic [7:0]  a_source_i;
  logic [31:0] a_address_i;
  logic [3:0]  a_mask_i;
  logic [31:0] a_data_i;
  logic        d_valid_o;
  logic        d_ready_i;
  logic [2:0]  d_opcode_o;
  logic [1:0]  d_size_o;
  logic [7:0]  d_source_o;
  logic [31:0] d_data_o;
  logic        d_error_o;

  integer      seed;
  integer      cycle_count;
  logic        bp_on;
  logic [31:0] bp_draw;
  logic [31:0] shadow [2**sram_aw];
  resp_t       exp_q [$];
  int          exp_count;
  logic        exp_valid;
  logic [2:0]  exp_opcode;
  logic [1:0]  exp_size;
  logic [7:0]  exp_source;
  logic [31:0] exp_data;
  logic        exp_error;
  logic        a_fire;
  logic        d_fire;

  sram_bridge_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o)
  );

  always #50 clk_i = ~clk_i;

  assign a_fire = a_valid_i & a_ready_o;
  assign d_fire = d_valid_o & d_ready_i;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  // Legality rules of an A request, written out from the protocol rules
  function automatic logic expected_error(input logic [2:0] op, input logic [1:0] size,
                                          input logic [31:0] addr, input logic [3:0] mask);
    logic [3:0] lane;
    logic       err;
    err = !(op == put_full_data || op == put_partial_data || op == get);
    err = err | (size == 2'd3);
    // Byte count is 1 << size and the address must be a multiple of it
    err = err | ((addr & ((32'd1 << size) - 1)) != 0);
    if (size == 2'd0) begin
      lane = 4'b0001 << addr[1:0];
    end else if (size == 2'd1) begin
      lane = addr[1] ? 4'b1100 : 4'b0011;
    end else begin
      lane = 4'b1111;
    end
    err = err | ((mask & ~lane) != 0);
    err = err | ((op == get || op == put_full_data) && mask == 4'b0000);
    err = err | (op == put_full_data && (mask & lane) != lane);
    return err;
  endfunction

  // Tests only touch words 0 to 15 and the upper bits pick an alias
  function automatic logic [31:0] word_address(input logic [3:0] word,
                                               input logic [19:0] alias_bits);
    return {alias_bits, 6'b000000, word, 2'b00};
  endfunction

  // Holds the request until a_ready_o is seen high before a rising edge
  task automatic send(input logic [2:0] op, input logic [1:0] size, input logic [7:0] source,
                      input logic [31:0] addr, input logic [3:0] mask, input logic [31:0] data);
    logic taken;
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_size_i    = size;
    a_source_i  = source;
    a_address_i = addr;
    a_mask_i    = mask;
    a_data_i    = data;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = a_ready_o;
      @(posedge clk_i);
      #1;
    end
    a_valid_i = 1'b0;
  endtask

  task automatic drain_responses();
    do begin
      @(negedge clk_i);
    end while (exp_count != 0);
    @(posedge clk_i);
    #1;
  endtask

  // The scoreboard and shadow memory are updated on every handshake
  always @(posedge clk_i) begin : scoreboard
    resp_t      exp;
    logic [9:0] idx;
    if (rst_i) begin
      exp_q.delete();
    end else begin
      if (d_fire && exp_q.size() > 0) begin
        exp = exp_q.pop_front();
      end
      if (a_fire) begin
        idx        = a_address_i[sram_aw+1:2];
        exp.error  = expected_error(a_opcode_i, a_size_i, a_address_i, a_mask_i);
        exp.opcode = (a_opcode_i == get) ? access_ack_data : access_ack;
        exp.size   = a_size_i;
        exp.source = a_source_i;
        exp.data   = (a_opcode_i == get && !exp.error) ? shadow[idx] : 32'h0;
        if (!exp.error && a_opcode_i != get) begin
          for (int b = 0; b < 4; b++) begin
            if (a_mask_i[b]) begin
              shadow[idx][8*b +: 8] = a_data_i[8*b +: 8];
            end
          end
        end
        exp_q.push_back(exp);
      end
    end
    exp_count = exp_q.size();
    exp_valid = (exp_count != 0);
    if (exp_valid) begin
      {exp_opcode, exp_size, exp_source, exp_data, exp_error} = exp_q[0];
    end
  end

  // Every D transfer must match the oldest outstanding request
  resp_pending: assert property (@(posedge clk_i) disable iff (rst_i) d_fire |-> exp_valid)
    else stop_with_failure("A D response arrived while no request was outstanding");
  resp_opcode: assert property (@(posedge clk_i) disable iff (rst_i)
                                d_fire |-> d_opcode_o == exp_opcode)
    else stop_with_failure($sformatf("FAIL at %0t: d_opcode_o %0d, expected %0d",
                                     $time, $sampled(d_opcode_o), $sampled(exp_opcode)));
  resp_size: assert property (@(posedge clk_i) disable iff (rst_i) d_fire |-> d_size_o == exp_size)
    else stop_with_failure($sformatf("FAIL at %0t: d_size_o %0d, expected %0d",
                                     $time, $sampled(d_size_o), $sampled(exp_size)));
  resp_source: assert property (@(posedge clk_i) disable iff (rst_i)
                                d_fire |-> d_source_o == exp_source)
    else stop_with_failure($sformatf("FAIL at %0t: d_source_o %h, expected %h",
                                     $time, $sampled(d_source_o), $sampled(exp_source)));
  resp_data: assert property (@(posedge clk_i) disable iff (rst_i) d_fire |-> d_data_o == exp_data)
    else stop_with_failure($sformatf("FAIL at %0t: d_data_o %h, expected %h",
                                     $time, $sampled(d_data_o), $sampled(exp_data)));
  resp_error: assert property (@(posedge clk_i) disable iff (rst_i)
                               d_fire |-> d_error_o == exp_error)
    else stop_with_failure($sformatf("FAIL at %0t: d_error_o %b, expected %b",
                                     $time, $sampled(d_error_o), $sampled(exp_error)));
  // With nothing pending the response follows its request after one cycle
  resp_latency: assert property (@(posedge clk_i) disable iff (rst_i)
                                 a_fire && !exp_valid |=> d_valid_o)
    else stop_with_failure($sformatf("FAIL at %0t: d_valid_o not high one cycle after A", $time));
  // The A channel stalls exactly when Outstanding+1 responses are pending
  a_ready_level: assert property (@(posedge clk_i) disable iff (rst_i)
                                  a_ready_o == (exp_count < outstanding + 1))
    else stop_with_failure($sformatf("FAIL at %0t: a_ready_o %b with %0d responses pending",
                                     $time, $sampled(a_ready_o), $sampled(exp_count)));
  d_hold: assert property (@(posedge clk_i) disable iff (rst_i) d_valid_o && !d_ready_i |=>
                           d_valid_o && $stable(d_data_o) && $stable(d_source_o) &&
                           $stable(d_size_o) && $stable(d_opcode_o) && $stable(d_error_o))
    else stop_with_failure($sformatf("FAIL at %0t: D response changed while stalled", $time));

  // Back-pressure is drawn at the falling edge and driven after the rising edge
  always @(negedge clk_i) bp_draw = $random(seed);

  always @(posedge clk_i) begin
    #1;
    d_ready_i = !bp_on || (bp_draw[1:0] == 2'b00);
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      stop_with_failure("Timeout: the tests did not complete within the cycle limit");
    end
  end

  initial begin : stimulus
    logic [31:0] pick;
    logic [2:0]  op;
    logic [3:0]  mask;
    seed        = 83;
    cycle_count = 0;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    bp_on       = 1'b0;
    bp_draw     = '0;
    d_ready_i   = 1'b1;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_size_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Full-word writes to every test word are followed by in-order reads
    for (int w = 0; w < 16; w++) begin
      send(put_full_data, 2'd2, 8'(w), word_address(4'(w), 20'h0), 4'hf, $random(seed));
    end
    drain_responses();
    for (int w = 0; w < 16; w++) begin
      send(get, 2'd2, 8'(8'h40 + w), word_address(4'(w), 20'h0), 4'hf, 32'h0);
    end
    drain_responses();

    // Byte and masked word writes merge into the stored words
    for (int w = 0; w < 16; w++) begin
      pick = $random(seed);
      send(put_partial_data, 2'd0, pick[15:8], word_address(4'(w), 20'h0) | pick[1:0],
           4'b0001 << pick[1:0], $random(seed));
      send(put_partial_data, 2'd2, pick[23:16], word_address(4'(w), 20'h0), pick[7:4],
           $random(seed));
      send(get, 2'd2, pick[31:24], word_address(4'(w), 20'h0), 4'hf, 32'h0);
    end
    drain_responses();

    // Illegal requests are followed by reads showing the words were not touched
    send(3'd2, 2'd2, 8'h90, word_address(4'd1, 20'h0), 4'hf, 32'hdeadbeef);
    send(get, 2'd3, 8'h91, word_address(4'd2, 20'h0), 4'hf, 32'h0);
    send(get, 2'd2, 8'h92, word_address(4'd3, 20'h0) | 32'd1, 4'hf, 32'h0);
    send(put_partial_data, 2'd0, 8'h93, word_address(4'd4, 20'h0), 4'b0010, 32'h12345678);
    send(put_full_data, 2'd2, 8'h94, word_address(4'd5, 20'h0), 4'b0111, 32'hcafef00d);
    send(put_partial_data, 2'd1, 8'h95, word_address(4'd6, 20'h0) | 32'd1, 4'b0011, 32'h0);
    for (int w = 1; w < 7; w++) begin
      send(get, 2'd2, 8'(8'ha0 + w), word_address(4'(w), 20'h0), 4'hf, 32'h0);
    end
    drain_responses();

    // A write through one alias is read back through two others
    send(put_full_data, 2'd2, 8'hb0, word_address(4'd7, 20'h80000), 4'hf, 32'ha5a55a5a);
    send(get, 2'd2, 8'hb1, word_address(4'd7, 20'h00001), 4'hf, 32'h0);
    send(put_partial_data, 2'd1, 8'hb2, word_address(4'd7, 20'hfffff) | 32'd2, 4'b1100,
         32'h77660000);
    send(get, 2'd2, 8'hb3, word_address(4'd7, 20'h12345), 4'hf, 32'h0);
    drain_responses();

    // Random traffic against a randomly stalled D channel
    bp_on = 1'b1;
    repeat (200) begin
      pick = $random(seed);
      case (pick[5:4])
        2'd0:    op = get;
        2'd1:    op = put_full_data;
        2'd2:    op = put_partial_data;
        default: op = pick[6] ? get : 3'd3;
      endcase
      mask = (op == put_partial_data) ? pick[11:8] : 4'hf;
      send(op, 2'd2, pick[19:12], word_address(pick[3:0], pick[31:12]), mask, $random(seed));
    end
    bp_on = 1'b0;
    drain_responses();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- logic/sram_bridge_top.sv
// Bridge top level that joins the TileLink-UL adapter to the SRAM array
// and sets the parameters of both
`timescale 1ns/100ps

module sram_bridge_top import sram_bridge_pkg::*; #(
  parameter int SramAw      = 10,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1,
  parameter bit ErrOnWrite  = 1'b0,
  parameter bit ErrOnRead   = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // A channel from the host
  input  logic              a_valid_i,
  output logic              a_ready_o,
  input  logic [2:0]        a_opcode_i,
  input  logic [tl_szw-1:0] a_size_i,
  input  logic [tl_aiw-1:0] a_source_i,
  input  logic [tl_aw-1:0]  a_address_i,
  input  logic [tl_dbw-1:0] a_mask_i,
  input  logic [tl_dw-1:0]  a_data_i,
  // D channel back to the host
  output logic              d_valid_o,
  input  logic              d_ready_i,
  output logic [2:0]        d_opcode_o,
  output logic [tl_szw-1:0] d_size_o,
  output logic [tl_aiw-1:0] d_source_o,
  output logic [tl_dw-1:0]  d_data_o,
  output logic              d_error_o
);

  // Adapter to memory port
  sram_port_if #(.SramAw(SramAw)) u_sram_port ();

  tl_sram_adapter #(
    .SramAw      (SramAw),
    .Outstanding (Outstanding),
    .ByteAccess  (ByteAccess),
    .ErrOnWrite  (ErrOnWrite),
    .ErrOnRead   (ErrOnRead)
  ) u_adapter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .mem         (u_sram_port)
  );

  sram_array #(
    .SramAw (SramAw)
  ) u_array (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .mem   (u_sram_port)
  );

endmodule

//--- logic/sram_array.sv
// Single-port word-addressed memory with bit write masks and a
// one-cycle registered read return
`timescale 1ns/100ps

module sram_array import sram_bridge_pkg::*; #(
  parameter int SramAw = 10
) (
  input  logic     clk_i,
  input  logic     rst_i,
  sram_port_if.mem mem
);

  localparam int Words = 2 ** SramAw;

  logic [tl_dw-1:0] store_q [Words];
  logic [tl_dw-1:0] rdata_q;
  logic             rvalid_q;
  logic             wr_en;
  logic             rd_en;

  // The array takes an access on every strobe, there is no grant
  assign wr_en = mem.req & mem.we;
  assign rd_en = mem.req & ~mem.we;

  // Read return strobe, cleared by reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  // Write merges the selected bits into the stored word
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      store_q[mem.addr] <= (store_q[mem.addr] & ~mem.wmask) | (mem.wdata & mem.wmask);
    end
  end

  // Read data is registered and held until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= store_q[mem.addr];
    end
  end

  assign mem.rdata  = rdata_q;
  assign mem.rvalid = rvalid_q;

endmodule

//--- logic/tl_sram_adapter.sv
// TileLink-UL adapter for a single-port SRAM with request checking and
// in-order AccessAck / AccessAckData responses
`timescale 1ns/100ps

module tl_sram_adapter import sram_bridge_pkg::*; #(
  parameter int SramAw      = 10,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1,
  parameter bit ErrOnWrite  = 1'b0,
  parameter bit ErrOnRead   = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              a_valid_i,
  output logic              a_ready_o,
  input  logic [2:0]        a_opcode_i,
  input  logic [tl_szw-1:0] a_size_i,
  input  logic [tl_aiw-1:0] a_source_i,
  input  logic [tl_aw-1:0]  a_address_i,
  input  logic [tl_dbw-1:0] a_mask_i,
  input  logic [tl_dw-1:0]  a_data_i,
  output logic              d_valid_o,
  input  logic              d_ready_i,
  output logic [2:0]        d_opcode_o,
  output logic [tl_szw-1:0] d_size_o,
  output logic [tl_aiw-1:0] d_source_o,
  output logic [tl_dw-1:0]  d_data_o,
  output logic              d_error_o,
  sram_port_if.host         mem
);

  tl_a_op_e   a_op;
  logic       a_ack;
  logic       d_ack;
  logic       d_valid;
  logic       req_error;
  logic       is_write;
  logic       clean_read;
  logic       reqfifo_wready;
  logic       reqfifo_rvalid;
  req_entry_t reqfifo_wdata;
  req_entry_t reqfifo_rdata;
  logic       rspfifo_rvalid;
  logic       rspfifo_rready;
  rsp_entry_t rspfifo_wdata;
  rsp_entry_t rspfifo_rdata;

  // The raw opcode may hold any 3-bit value, the checker sorts out the bad ones
  assign a_op     = tl_a_op_e'(a_opcode_i);
  assign is_write = (a_op == put_full_data) | (a_op == put_partial_data);

  tl_req_checker #(
    .ByteAccess (ByteAccess),
    .ErrOnWrite (ErrOnWrite),
    .ErrOnRead  (ErrOnRead)
  ) u_checker (
    .opcode_i  (a_op),
    .size_i    (a_size_i),
    .address_i (a_address_i),
    .mask_i    (a_mask_i),
    .error_o   (req_error)
  );

  // Requests are taken whenever the request FIFO has room, errors included
  assign a_ready_o = reqfifo_wready;
  assign a_ack     = a_valid_i & a_ready_o;

  // Legal requests go to the SRAM in the same cycle they are accepted
  // Erroneous ones only leave a FIFO entry behind for the error response
  assign mem.req  = a_ack & ~req_error;
  assign mem.we   = a_valid_i & is_write;
  // Word address with no base offset, so the upper address bits alias
  assign mem.addr = a_address_i[SramAw+1:2];

  // Byte enables become a bit mask, and only enabled write bytes are driven
  always_comb begin
    for (int i = 0; i < tl_dbw; i++) begin
      mem.wmask[8*i +: 8] = {8{a_mask_i[i]}};
      mem.wdata[8*i +: 8] = (a_mask_i[i] && mem.we) ? a_data_i[8*i +: 8] : 8'h00;
    end
  end

  // Only the kind of access and the echo fields are stored, never write data
  always_comb begin
    reqfifo_wdata.error  = req_error;
    reqfifo_wdata.size   = a_size_i;
    reqfifo_wdata.source = a_source_i;
    if (a_op == get) begin
      reqfifo_wdata.op = op_read;
    end else if (is_write) begin
      reqfifo_wdata.op = op_write;
    end else begin
      reqfifo_wdata.op = op_unknown;
    end
  end

  // Depth of Outstanding+1 lets back-to-back requests flow without a bubble
  // and keeps a_ready_o free of any path from d_ready_i
  sync_fifo #(
    .entry_t (req_entry_t),
    .Depth   (Outstanding + 1),
    .Pass    (1'b0)
  ) u_reqfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (a_ack),
    .wready_o (reqfifo_wready),
    .wdata_i  (reqfifo_wdata),
    .rvalid_o (reqfifo_rvalid),
    .rready_i (d_ack),
    .rdata_o  (reqfifo_rdata)
  );

  // The SRAM cannot be stalled, so read data always lands here
  // Every read in flight owns a request FIFO slot, so this FIFO never overflows
  assign rspfifo_wdata.data = mem.rdata;

  sync_fifo #(
    .entry_t (rsp_entry_t),
    .Depth   (Outstanding + 1),
    .Pass    (1'b1)
  ) u_rspfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (mem.rvalid),
    .wready_o (),
    .wdata_i  (rspfifo_wdata),
    .rvalid_o (rspfifo_rvalid),
    .rready_i (rspfifo_rready),
    .rdata_o  (rspfifo_rdata)
  );

  // A read that reached the SRAM has to wait for its data
  // Writes and error responses can go out as soon as they reach the head
  assign clean_read = reqfifo_rvalid & (reqfifo_rdata.op == op_read) & ~reqfifo_rdata.error;
  assign d_valid    = reqfifo_rvalid & (~clean_read | rspfifo_rvalid);
  assign d_ack      = d_valid & d_ready_i;

  // Read data is consumed together with its request entry
  assign rspfifo_rready = d_ack & clean_read;

  assign d_valid_o  = d_valid;
  assign d_opcode_o = (d_valid && reqfifo_rdata.op == op_read) ? access_ack_data : access_ack;
  assign d_size_o   = d_valid ? reqfifo_rdata.size : '0;
  assign d_source_o = d_valid ? reqfifo_rdata.source : '0;
  // Data stays zero for writes and for every error response
  assign d_data_o   = (d_valid && clean_read) ? rspfifo_rdata.data : '0;
  assign d_error_o  = d_valid & reqfifo_rdata.error;

endmodule

//--- logic/sync_fifo.sv
// Synchronous circular-buffer FIFO with a typed payload and an optional
// pass-through path for the empty case
`timescale 1ns/100ps

module sync_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  Depth   = 2,
  parameter bit  Pass    = 1'b1
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   wvalid_i,
  output logic   wready_o,
  input  entry_t wdata_i,
  output logic   rvalid_o,
  input  logic   rready_i,
  output entry_t rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  entry_t          storage_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] count_q;
  logic            empty;
  logic            full;
  logic            pass_through;
  logic            push;
  logic            pop;

  assign empty    = (count_q == '0);
  assign full     = (count_q == CntW'(Depth));
  assign wready_o = ~full;

  // An empty pass-through FIFO shows the incoming entry straight away
  assign pass_through = Pass & empty;
  assign rvalid_o     = ~empty | (pass_through & wvalid_i);
  assign rdata_o      = pass_through ? wdata_i : storage_q[rptr_q];

  // An entry that is taken in the cycle it arrives never gets stored
  assign push = wvalid_i & ~full & ~(pass_through & rready_i);
  assign pop  = rready_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the fill level unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      storage_q[wptr_q] <= wdata_i;
    end
  end

endmodule

//--- logic/tl_req_checker.sv
// Combinational protocol and policy check of one A-channel request
`timescale 1ns/100ps

module tl_req_checker import sram_bridge_pkg::*; #(
  parameter bit ByteAccess = 1'b1,
  parameter bit ErrOnWrite = 1'b0,
  parameter bit ErrOnRead  = 1'b0
) (
  input  tl_a_op_e          opcode_i,
  input  logic [tl_szw-1:0] size_i,
  input  logic [tl_aw-1:0]  address_i,
  input  logic [tl_dbw-1:0] mask_i,
  output logic              error_o
);

  logic              is_get;
  logic              is_put_full;
  logic              is_write;
  logic              op_error;
  logic              size_error;
  logic              align_error;
  logic              mask_error;
  logic              full_error;
  logic              attr_error;
  logic              policy_error;
  logic [tl_dbw-1:0] lane;

  assign is_get      = (opcode_i == get);
  assign is_put_full = (opcode_i == put_full_data);
  assign is_write    = is_put_full | (opcode_i == put_partial_data);

  // Anything other than Get, PutFullData or PutPartialData is rejected
  assign op_error   = ~(is_get | is_write);
  // The size field is log2 of the byte count, and a 32-bit bus stops at 4 bytes
  assign size_error = (size_i > 2'd2);

  // Byte lanes covered by the sized access at this address
  always_comb begin
    case (size_i)
      2'd0:    lane = 4'b0001 << address_i[1:0];
      2'd1:    lane = 4'b0011 << {address_i[1], 1'b0};
      default: lane = 4'b1111;
    endcase
  end

  // Halfwords need an even address and words need a word address
  always_comb begin
    case (size_i)
      2'd1:    align_error = address_i[0];
      2'd2:    align_error = |address_i[1:0];
      default: align_error = 1'b0;
    endcase
  end

  // No mask bit may sit outside the lane, and Get or PutFull needs at least one
  assign mask_error = (|(mask_i & ~lane)) | ((is_get | is_put_full) & (mask_i == '0));
  // A full write must enable every byte of its lane
  assign full_error = is_put_full & ((mask_i & lane) != lane);

  // Without byte access only whole-word writes are allowed
  assign attr_error = ~ByteAccess & is_write & ((mask_i != '1) | (size_i != 2'd2));

  // Read-only or write-only memories turn the other direction into an error
  assign policy_error = (ErrOnWrite & is_write) | (ErrOnRead & is_get);

  assign error_o = op_error | size_error | align_error | mask_error |
                   full_error | attr_error | policy_error;

endmodule

//--- logic/sram_port_if.sv
// Port between the adapter and the SRAM array, with a host end and a
// memory end
`timescale 1ns/100ps

interface sram_port_if import sram_bridge_pkg::*; #(
  parameter int SramAw = 10
) ();

  // Request side, one strobe per access and no back-pressure
  logic              req;
  logic              we;
  logic [SramAw-1:0] addr;
  logic [tl_dw-1:0]  wdata;
  logic [tl_dw-1:0]  wmask;

  // Read return, valid for exactly one cycle
  logic [tl_dw-1:0]  rdata;
  logic              rvalid;

  // The adapter issues accesses and collects read data
  modport host (
    output req, we, addr, wdata, wmask,
    input  rdata, rvalid
  );

  // The array serves accesses and returns read data
  modport mem (
    input  req, we, addr, wdata, wmask,
    output rdata, rvalid
  );

endinterface

//--- logic/sram_bridge_pkg.sv
// Shared bus widths, channel opcodes and FIFO entry types for the
// TileLink-UL to SRAM bridge
package sram_bridge_pkg;

  // TileLink-UL field widths
  parameter int tl_dw  = 32;
  parameter int tl_aw  = 32;
  parameter int tl_aiw = 8;
  parameter int tl_szw = 2;

  // One mask bit per data byte
  parameter int tl_dbw = tl_dw / 8;

  // A-channel opcodes that the adapter understands
  typedef enum logic [2:0] {
    put_full_data    = 3'd0,
    put_partial_data = 3'd1,
    get              = 3'd4
  } tl_a_op_e;

  // D-channel response opcodes
  typedef enum logic [2:0] {
    access_ack      = 3'd0,
    access_ack_data = 3'd1
  } tl_d_op_e;

  // Kind of access remembered for each accepted request
  typedef enum logic [1:0] {
    op_write,
    op_read,
    op_unknown
  } req_op_e;

  // Request FIFO entry, enough to build the D response later
  typedef struct packed {
    req_op_e           op;
    logic              error;
    logic [tl_szw-1:0] size;
    logic [tl_aiw-1:0] source;
  } req_entry_t;

  // Response FIFO entry with the word read back from the array
  typedef struct packed {
    logic [tl_dw-1:0] data;
  } rsp_entry_t;

endpackage
